// ==== logic/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Program store size in 16-bit words
`define CPU_PROG_DEPTH 256

// Transmit FIFO entries
`define CPU_FIFO_DEPTH 4

// System clocks per serial bit
`define CPU_BAUD_DIV 4

// Host APB byte address width and control/status register
`define CPU_HOST_AW 12
`define CPU_HOST_CTRL_ADDR 12'h400

`endif

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [7:0]  word_t;     // Data path width
    typedef logic [15:0] instr_t;    // Instruction word
    typedef logic [7:0]  pc_t;       // Program address
    typedef logic [1:0]  reg_idx_t;  // Register select
    typedef logic [2:0]  flags_t;    // {c, z, n}

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_MOVB = 3'd5   // Pass b through
    } alu_op_e;

    // Bit 15 set selects a register as the b operand
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_XOR    = 4'd4,
        OP_MOVB   = 4'd5,
        OP_OUT    = 4'd6,
        OP_JMP    = 4'd7,
        OP_ADD_R  = 4'd8,
        OP_SUB_R  = 4'd9,
        OP_AND_R  = 4'd10,
        OP_OR_R   = 4'd11,
        OP_XOR_R  = 4'd12,
        OP_MOVB_R = 4'd13,
        OP_HALT   = 4'd14,
        OP_NOP    = 4'd15
    } opcode_e;

    typedef enum logic [1:0] {
        COND_ALWAYS = 2'd0,
        COND_Z      = 2'd1,
        COND_NZ     = 2'd2,
        COND_C      = 2'd3
    } cond_e;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_EXEC, ST_OUT_SETUP, ST_OUT_ACCESS
    } ctrl_state_e;

endpackage

// ==== logic/cpu_host_port.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_host_port (
    input  logic                    system_clk,
    input  logic                    rst_n,
    input  logic [`CPU_HOST_AW-1:0] host_paddr,
    input  logic                    host_psel,
    input  logic                    host_penable,
    input  logic                    host_pwrite,
    input  cpu_pkg::instr_t         host_pwdata,
    input  logic                    busy,
    input  cpu_pkg::pc_t            fetch_addr,
    output cpu_pkg::instr_t         host_prdata,
    output logic                    host_pslverr,
    output logic                    start,
    output cpu_pkg::instr_t         fetch_instr
);

    localparam int PW = $clog2(`CPU_PROG_DEPTH);

    cpu_pkg::instr_t prog_mem [`CPU_PROG_DEPTH];

    logic          setup_ph;
    logic          access_ph;
    logic          prog_sel;
    logic          ctrl_sel;
    logic [PW-1:0] word_idx;

    assign setup_ph  = host_psel & ~host_penable;
    assign access_ph = host_psel & host_penable;
    assign prog_sel  = host_paddr < `CPU_HOST_CTRL_ADDR;   // Program words below control reg
    assign ctrl_sel  = host_paddr == `CPU_HOST_CTRL_ADDR;
    assign word_idx  = host_paddr[PW+1:2];                 // Byte to word address

    // Program write refused while running
    assign host_pslverr = access_ph & host_pwrite & prog_sel & busy;

    always_ff @(posedge system_clk) begin
        if (access_ph && host_pwrite && prog_sel && !busy)
            prog_mem[word_idx] <= host_pwdata;
        fetch_instr <= prog_mem[fetch_addr];   // Sync fetch port
    end

    // Read data captured in setup, valid through the access phase
    always_ff @(posedge system_clk) begin
        if (setup_ph) begin
            if (prog_sel)
                host_prdata <= prog_mem[word_idx];
            else if (ctrl_sel)
                host_prdata <= cpu_pkg::instr_t'(busy);   // Status bit 0
            else
                host_prdata <= '0;                         // Unmapped
        end
    end

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n)
            start <= 1'b0;
        else
            start <= access_ph & host_pwrite & ctrl_sel & host_pwdata[0] & ~busy;
    end

    // Start only from idle, and the controller must take it
    a_start_idle: assert property (@(posedge system_clk) disable iff (!rst_n)
        start |-> !busy ##1 busy);

endmodule

// ==== logic/cpu_controller.sv ====
`timescale 1ns/1ns

module cpu_controller (
    input  logic                  system_clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  cpu_pkg::instr_t       fetch_instr,
    input  cpu_pkg::word_t        rd_a_data,
    input  cpu_pkg::flags_t       flags,
    input  cpu_pkg::word_t        alu_result,
    input  logic                  fifo_pready,
    output logic                  busy,
    output cpu_pkg::pc_t          fetch_addr,
    output cpu_pkg::reg_idx_t     rd_a_idx,
    output cpu_pkg::reg_idx_t     rd_b_idx,
    output logic                  wr_en,
    output cpu_pkg::reg_idx_t     wr_idx,
    output logic                  b_sel_imm,
    output cpu_pkg::word_t        imm,
    output cpu_pkg::alu_op_e      alu_op,
    output logic                  flags_we,
    output logic                  fifo_psel,
    output logic                  fifo_penable,
    output cpu_pkg::word_t        fifo_pwdata
);

    cpu_pkg::ctrl_state_e state_q;
    cpu_pkg::pc_t         pc_q;
    cpu_pkg::opcode_e     op;
    cpu_pkg::cond_e       cond;
    logic                 in_exec;
    logic                 is_alu;
    logic                 is_out;
    logic                 take_jmp;

    // Field decode
    assign op      = cpu_pkg::opcode_e'(fetch_instr[15:12]);
    assign cond    = cpu_pkg::cond_e'(fetch_instr[11:10]);   // dst doubles as condition
    assign in_exec = state_q == cpu_pkg::ST_EXEC;
    assign is_alu  = fetch_instr[14:12] < 3'd6;                // 0-5 and 8-13
    assign is_out  = op == cpu_pkg::OP_OUT;

    assign rd_a_idx = fetch_instr[9:8];
    assign rd_b_idx = fetch_instr[1:0];
    assign wr_idx   = fetch_instr[11:10];

    // OUT routes srca through the ALU as a OR 0, like the result bus of the TTL build
    assign b_sel_imm = ~fetch_instr[15] | is_out;
    assign imm       = is_out ? '0 : fetch_instr[7:0];
    assign alu_op    = is_out ? cpu_pkg::ALU_OR : cpu_pkg::alu_op_e'(fetch_instr[14:12]);

    assign wr_en    = in_exec & is_alu;
    assign flags_we = in_exec & is_alu;   // Flags move on ALU ops only

    always_comb begin
        case (cond)
            cpu_pkg::COND_Z:  take_jmp = flags[1];
            cpu_pkg::COND_NZ: take_jmp = ~flags[1];
            cpu_pkg::COND_C:  take_jmp = flags[2];
            default:          take_jmp = 1'b1;   // Always
        endcase
    end

    assign busy         = state_q != cpu_pkg::ST_IDLE;
    assign fetch_addr   = pc_q;
    assign fifo_psel    = (state_q == cpu_pkg::ST_OUT_SETUP) | (state_q == cpu_pkg::ST_OUT_ACCESS);
    assign fifo_penable = state_q == cpu_pkg::ST_OUT_ACCESS;

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= cpu_pkg::ST_IDLE;
            pc_q    <= '0;
        end else begin
            case (state_q)
                cpu_pkg::ST_IDLE: begin
                    if (start) begin
                        pc_q    <= '0;                  // Always run from word 0
                        state_q <= cpu_pkg::ST_FETCH;
                    end
                end
                cpu_pkg::ST_FETCH: state_q <= cpu_pkg::ST_EXEC;   // Wait for sync ROM read
                cpu_pkg::ST_EXEC: begin
                    case (op)
                        cpu_pkg::OP_HALT: state_q <= cpu_pkg::ST_IDLE;
                        cpu_pkg::OP_OUT: begin
                            pc_q    <= pc_q + 1'b1;
                            state_q <= cpu_pkg::ST_OUT_SETUP;
                        end
                        cpu_pkg::OP_JMP: begin
                            pc_q    <= take_jmp ? fetch_instr[7:0] : pc_q + 1'b1;
                            state_q <= cpu_pkg::ST_FETCH;
                        end
                        default: begin
                            pc_q    <= pc_q + 1'b1;     // ALU ops and NOP
                            state_q <= cpu_pkg::ST_FETCH;
                        end
                    endcase
                end
                cpu_pkg::ST_OUT_SETUP: state_q <= cpu_pkg::ST_OUT_ACCESS;
                cpu_pkg::ST_OUT_ACCESS: begin
                    if (fifo_pready)
                        state_q <= cpu_pkg::ST_FETCH;   // Hold until FIFO has room
                end
                default: state_q <= cpu_pkg::ST_IDLE;
            endcase
        end
    end

    // Byte held from EXEC until the FIFO accepts it
    always_ff @(posedge system_clk) begin
        if (in_exec && is_out)
            fifo_pwdata <= alu_result;
    end

    a_apb_hold: assert property (@(posedge system_clk) disable iff (!rst_n)
        (fifo_penable && !fifo_pready) |=> (fifo_psel && $stable(fifo_pwdata)));

    // ALU pass-through must present the source register unchanged
    a_out_route: assert property (@(posedge system_clk) disable iff (!rst_n)
        (in_exec && is_out) |-> alu_result == rd_a_data);

endmodule

// ==== logic/cpu_register_file.sv ====
`timescale 1ns/1ns

module cpu_register_file (
    input  logic              system_clk,
    input  logic              rst_n,
    input  logic              wr_en,
    input  cpu_pkg::reg_idx_t wr_idx,
    input  cpu_pkg::word_t    wr_data,
    input  cpu_pkg::reg_idx_t rd_a_idx,
    input  cpu_pkg::reg_idx_t rd_b_idx,
    output cpu_pkg::word_t    rd_a_data,
    output cpu_pkg::word_t    rd_b_data
);

    cpu_pkg::word_t regs [4];   // r0..r3

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;   // Lands at end of EXEC
        end
    end

    // Async read ports
    assign rd_a_data = regs[rd_a_idx];
    assign rd_b_data = regs[rd_b_idx];

endmodule

// ==== logic/cpu_alu.sv ====
`timescale 1ns/1ns

module cpu_alu (
    input  logic             system_clk,
    input  logic             rst_n,
    input  cpu_pkg::alu_op_e alu_op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  logic             flags_we,
    output cpu_pkg::word_t   result,
    output cpu_pkg::flags_t  flags
);

    logic [8:0] wide;     // Result with carry/borrow bit
    logic       c_next;

    always_comb begin
        wide = '0;
        case (alu_op)
            cpu_pkg::ALU_ADD:  wide = {1'b0, a} + {1'b0, b};
            cpu_pkg::ALU_SUB:  wide = {1'b0, a} - {1'b0, b};   // Bit 8 set on borrow
            cpu_pkg::ALU_AND:  wide = {1'b0, a & b};
            cpu_pkg::ALU_OR:   wide = {1'b0, a | b};
            cpu_pkg::ALU_XOR:  wide = {1'b0, a ^ b};
            cpu_pkg::ALU_MOVB: wide = {1'b0, b};
            default:           wide = '0;
        endcase
        // Logic ops and MOVB clear carry through the zero top bit
        c_next = wide[8];
    end

    assign result = wide[7:0];

    // Registered c, z, n
    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n)
            flags <= '0;
        else if (flags_we)
            flags <= {c_next, result == '0, result[7]};
    end

endmodule

// ==== logic/uart_tx_fifo.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module uart_tx_fifo (
    input  logic           system_clk,
    input  logic           rst_n,
    input  logic           fifo_psel,
    input  logic           fifo_penable,
    input  cpu_pkg::word_t fifo_pwdata,
    input  logic           fifo_pop,
    output logic           fifo_pready,
    output cpu_pkg::word_t fifo_rdata,
    output logic           fifo_empty
);

    localparam int AW = $clog2(`CPU_FIFO_DEPTH);
    localparam int CW = $clog2(`CPU_FIFO_DEPTH + 1);

    cpu_pkg::word_t mem [`CPU_FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop_ok;

    assign fifo_pready = count != CW'(`CPU_FIFO_DEPTH);   // Back-pressure when full
    assign fifo_empty  = count == '0;
    assign fifo_rdata  = mem[rd_ptr];                     // Head byte
    assign push        = fifo_psel & fifo_penable & fifo_pready;
    assign pop_ok      = fifo_pop & ~fifo_empty;

    always_ff @(posedge system_clk) begin
        if (push)
            mem[wr_ptr] <= fifo_pwdata;
    end

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == AW'(`CPU_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= (rd_ptr == AW'(`CPU_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Serializer must only take a byte that is there
    a_no_pop_empty: assert property (@(posedge system_clk) disable iff (!rst_n)
        fifo_pop |-> !fifo_empty);
    a_count_max: assert property (@(posedge system_clk) disable iff (!rst_n)
        count <= CW'(`CPU_FIFO_DEPTH));

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module uart_tx (
    input  logic           system_clk,
    input  logic           rst_n,
    input  cpu_pkg::word_t fifo_rdata,
    input  logic           fifo_empty,
    output logic           fifo_pop,
    output logic           uart_txd
);

    localparam int BW = $clog2(`CPU_BAUD_DIV);

    logic [BW-1:0] baud_cnt;
    logic [3:0]    bit_cnt;    // 0 start, 1-8 data, 9 stop
    logic [8:0]    shift_q;    // LSB drives the line
    logic          active;
    logic          bit_done;
    logic          frame_end;

    assign bit_done  = active && (baud_cnt == BW'(`CPU_BAUD_DIV - 1));
    assign frame_end = bit_done && (bit_cnt == 4'd9);
    assign fifo_pop  = (!active || frame_end) && !fifo_empty;   // Back to back frames
    assign uart_txd  = shift_q[0];

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shift_q  <= '1;                         // Line idles high
        end else if (fifo_pop) begin
            active   <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shift_q  <= {fifo_rdata, 1'b0};         // Start bit first
        end else if (frame_end) begin
            active   <= 1'b0;
            baud_cnt <= '0;
        end else if (bit_done) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            shift_q  <= {1'b1, shift_q[8:1]};       // Ones fill in as stop/idle
        end else if (active) begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

// ==== logic/cpu.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu (
    input  logic                    system_clk,
    input  logic                    rst_n,
    input  logic [`CPU_HOST_AW-1:0] host_paddr,
    input  logic                    host_psel,
    input  logic                    host_penable,
    input  logic                    host_pwrite,
    input  cpu_pkg::instr_t         host_pwdata,
    output cpu_pkg::instr_t         host_prdata,
    output logic                    host_pslverr,
    output logic                    uart_txd
);

    logic              start;
    logic              busy;
    cpu_pkg::pc_t      fetch_addr;
    cpu_pkg::instr_t   fetch_instr;

    cpu_pkg::reg_idx_t rd_a_idx;
    cpu_pkg::reg_idx_t rd_b_idx;
    cpu_pkg::reg_idx_t wr_idx;
    logic              wr_en;
    cpu_pkg::word_t    rd_a_data;
    cpu_pkg::word_t    rd_b_data;

    logic              b_sel_imm;
    cpu_pkg::word_t    imm;
    cpu_pkg::word_t    alu_b;
    cpu_pkg::alu_op_e  alu_op;
    cpu_pkg::word_t    alu_result;
    logic              flags_we;
    cpu_pkg::flags_t   flags;

    logic              fifo_psel;
    logic              fifo_penable;
    logic              fifo_pready;
    cpu_pkg::word_t    fifo_pwdata;
    cpu_pkg::word_t    fifo_rdata;
    logic              fifo_empty;
    logic              fifo_pop;

    assign alu_b = b_sel_imm ? imm : rd_b_data;   // b operand mux

    cpu_host_port host_port_i (
        .system_clk, .rst_n,
        .host_paddr, .host_psel, .host_penable, .host_pwrite, .host_pwdata,
        .busy, .fetch_addr,
        .host_prdata, .host_pslverr, .start, .fetch_instr
    );

    cpu_controller ctrl_i (
        .system_clk, .rst_n,
        .start, .fetch_instr, .rd_a_data, .flags, .alu_result, .fifo_pready,
        .busy, .fetch_addr, .rd_a_idx, .rd_b_idx, .wr_en, .wr_idx,
        .b_sel_imm, .imm, .alu_op, .flags_we,
        .fifo_psel, .fifo_penable, .fifo_pwdata
    );

    cpu_register_file regfile_i (
        .system_clk, .rst_n,
        .wr_en, .wr_idx, .wr_data(alu_result),
        .rd_a_idx, .rd_b_idx, .rd_a_data, .rd_b_data
    );

    cpu_alu alu_i (
        .system_clk, .rst_n,
        .alu_op, .a(rd_a_data), .b(alu_b), .flags_we,
        .result(alu_result), .flags
    );

    uart_tx_fifo tx_fifo_i (
        .system_clk, .rst_n,
        .fifo_psel, .fifo_penable, .fifo_pwdata, .fifo_pop,
        .fifo_pready, .fifo_rdata, .fifo_empty
    );

    uart_tx uart_tx_i (
        .system_clk, .rst_n,
        .fifo_rdata, .fifo_empty,
        .fifo_pop, .uart_txd
    );

endmodule

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_tb;

    // Four clocks per host transfer or executed instruction, one frame per received byte
    localparam int STEPS       = 34 + 26 + 60 + 30 + 407 + 7 * 4;
    localparam int RX_BYTES    = 6 + 5 + 2 + 2 + 10;
    localparam int CYCLE_LIMIT = 4 * STEPS + 10 * `CPU_BAUD_DIV * RX_BYTES + 500;
    localparam logic [`CPU_HOST_AW-1:0] CTRL = `CPU_HOST_CTRL_ADDR;

    logic                    system_clk = 1'b0;
    logic                    rst_n;
    logic [`CPU_HOST_AW-1:0] host_paddr;
    logic                    host_psel;
    logic                    host_penable;
    logic                    host_pwrite;
    cpu_pkg::instr_t         host_pwdata;
    cpu_pkg::instr_t         host_prdata;
    logic                    host_pslverr;
    logic                    uart_txd;

    cpu_pkg::word_t rx_q[$];              // Bytes seen on the serial line
    logic [15:0]    lfsr = 16'd20;
    int             cycles = 0;
    int             value_errors = 0;
    int             protocol_errors = 0;  // Framing, lost bytes, timeout

    cpu cpu_i (.*);

    always #20 system_clk = ~system_clk;

    always @(posedge system_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Galois, maximal length taps
    endfunction

    // Takes n bits, one step each
    function logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic cpu_pkg::instr_t encode(input logic [3:0] op, input logic [1:0] dst,
                                               input logic [1:0] src, input cpu_pkg::word_t val);
        return {op, dst, src, val};
    endfunction

    function automatic logic [`CPU_HOST_AW-1:0] word_addr(input int idx);
        return {idx[9:0], 2'b00};   // Word index to byte address
    endfunction

    task automatic check_instr(input string name, input cpu_pkg::instr_t got,
                               input cpu_pkg::instr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic apb_write(input logic [`CPU_HOST_AW-1:0] addr, input cpu_pkg::instr_t data,
                             output logic slverr);
        @(posedge system_clk);
        host_paddr   <= addr;
        host_psel    <= 1'b1;
        host_penable <= 1'b0;
        host_pwrite  <= 1'b1;
        host_pwdata  <= data;
        @(posedge system_clk);
        host_penable <= 1'b1;
        @(negedge system_clk);
        slverr = host_pslverr;   // Mid access phase
        @(posedge system_clk);
        host_psel    <= 1'b0;
        host_penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [`CPU_HOST_AW-1:0] addr, output cpu_pkg::instr_t data);
        @(posedge system_clk);
        host_paddr   <= addr;
        host_psel    <= 1'b1;
        host_penable <= 1'b0;
        host_pwrite  <= 1'b0;
        @(posedge system_clk);
        host_penable <= 1'b1;
        @(negedge system_clk);
        data = host_prdata;
        @(posedge system_clk);
        host_psel    <= 1'b0;
        host_penable <= 1'b0;
    endtask

    task automatic load_program(input cpu_pkg::instr_t prog[$]);
        logic err;
        for (int i = 0; i < prog.size(); i++) begin
            apb_write(word_addr(i), prog[i], err);
            check_bit("host_pslverr", err, 1'b0);
        end
    endtask

    task automatic start_program();
        logic err;
        apb_write(CTRL, 16'h0001, err);
        check_bit("host_pslverr", err, 1'b0);   // Control writes are never refused
    endtask

    // Poll status until the controller is back in IDLE
    task automatic wait_idle();
        cpu_pkg::instr_t st;
        do begin
            apb_read(CTRL, st);
        end while (st[0] === 1'b1);
    endtask

    task automatic run_program(input cpu_pkg::instr_t prog[$]);
        load_program(prog);
        start_program();
        wait_idle();
    endtask

    // Waits for the expected bytes to drain through the FIFO and serializer
    task automatic check_rx_bytes(input cpu_pkg::word_t exp[$]);
        int budget;
        budget = (exp.size() + 2) * 10 * `CPU_BAUD_DIV;
        while (rx_q.size() < exp.size() && budget > 0) begin
            @(posedge system_clk);
            budget--;
        end
        if (rx_q.size() != exp.size()) begin
            protocol_errors++;
            $display("Serial line gave %0d bytes where %0d were due", rx_q.size(), exp.size());
        end
        for (int i = 0; i < exp.size() && i < rx_q.size(); i++)
            check_byte($sformatf("uart byte %0d", i), rx_q[i], exp[i]);
        rx_q.delete();
    endtask

    // Samples each bit near its centre, on the falling clock edge
    initial begin : uart_monitor
        cpu_pkg::word_t data;
        forever begin
            @(negedge system_clk);
            if (rst_n === 1'b1 && uart_txd === 1'b0) begin
                repeat (`CPU_BAUD_DIV / 2) @(negedge system_clk);
                if (uart_txd !== 1'b0) begin
                    protocol_errors++;
                    $display("Start bit did not stay low at its centre");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (`CPU_BAUD_DIV) @(negedge system_clk);
                    data[i] = uart_txd;   // LSB first
                end
                repeat (`CPU_BAUD_DIV) @(negedge system_clk);
                if (uart_txd !== 1'b1) begin
                    protocol_errors++;
                    $display("Stop bit was not high after byte 0x%h", data);
                end
                rx_q.push_back(data);
            end
        end
    end

    task automatic program_memory_readback();
        cpu_pkg::instr_t words[16];
        cpu_pkg::instr_t rd;
        logic            err;
        apb_read(CTRL, rd);
        check_bit("busy", rd[0], 1'b0);   // Idle out of reset
        for (int i = 0; i < 16; i++) begin
            words[i] = rand_bits(16);
            apb_write(word_addr(i), words[i], err);
            check_bit("host_pslverr", err, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            apb_read(word_addr(i), rd);
            check_instr($sformatf("prog word %0d", i), rd, words[i]);
        end
        apb_read(12'h800, rd);
        check_instr("unmapped read", rd, 16'h0000);
    endtask

    task automatic immediate_alu_ops();
        cpu_pkg::instr_t prog[$];
        cpu_pkg::word_t  exp[$];
        cpu_pkg::word_t  a;
        cpu_pkg::word_t  b[5];
        a = cpu_pkg::word_t'(rand_bits(8));
        for (int i = 0; i < 5; i++)
            b[i] = cpu_pkg::word_t'(rand_bits(8));
        prog.push_back(encode(cpu_pkg::OP_MOVB, 2'd1, 2'd0, a));
        prog.push_back(encode(cpu_pkg::OP_OUT, 2'd0, 2'd1, 8'd0));
        for (int i = 0; i < 5; i++) begin
            // Opcodes 0..4 are ADD, SUB, AND, OR, XOR with immediate b
            prog.push_back(encode(i[3:0], 2'd2, 2'd1, b[i]));
            prog.push_back(encode(cpu_pkg::OP_OUT, 2'd0, 2'd2, 8'd0));
        end
        prog.push_back(encode(cpu_pkg::OP_HALT, 2'd0, 2'd0, 8'd0));
        exp.push_back(a);
        exp.push_back(a + b[0]);
        exp.push_back(a - b[1]);   // Wraps on borrow
        exp.push_back(a & b[2]);
        exp.push_back(a | b[3]);
        exp.push_back(a ^ b[4]);
        run_program(prog);
        check_rx_bytes(exp);
    endtask

    task automatic countdown_loop();
        cpu_pkg::instr_t prog[$];
        cpu_pkg::word_t  exp[$];
        prog.push_back(encode(cpu_pkg::OP_MOVB, 2'd0, 2'd0, 8'd5));
        prog.push_back(encode(cpu_pkg::OP_MOVB, 2'd1, 2'd0, 8'd1));
        prog.push_back(encode(cpu_pkg::OP_OUT, 2'd0, 2'd0, 8'd0));
        prog.push_back(encode(cpu_pkg::OP_SUB_R, 2'd0, 2'd0, 8'd1));       // r0 -= r1
        prog.push_back(encode(cpu_pkg::OP_JMP, cpu_pkg::COND_NZ, 2'd0, 8'd2));
        prog.push_back(encode(cpu_pkg::OP_HALT, 2'd0, 2'd0, 8'd0));
        for (int n = 5; n > 0; n--)
            exp.push_back(n[7:0]);
        run_program(prog);
        check_rx_bytes(exp);
    endtask

    task automatic carry_jump();
        cpu_pkg::instr_t prog[$];
        cpu_pkg::word_t  exp[$];
        prog.push_back(encode(cpu_pkg::OP_MOVB, 2'd0, 2'd0, 8'hF0));
        prog.push_back(encode(cpu_pkg::OP_MOVB, 2'd1, 2'd0, 8'h20));
        prog.push_back(encode(cpu_pkg::OP_MOVB, 2'd3, 2'd0, 8'hC5));       // Marker
        prog.push_back(encode(cpu_pkg::OP_ADD, 2'd2, 2'd0, 8'h01));        // No carry
        prog.push_back(encode(cpu_pkg::OP_JMP, cpu_pkg::COND_C, 2'd0, 8'd6));
        prog.push_back(encode(cpu_pkg::OP_OUT, 2'd0, 2'd2, 8'd0));
        prog.push_back(encode(cpu_pkg::OP_ADD_R, 2'd2, 2'd0, 8'd1));       // F0 + 20 carries
        prog.push_back(encode(cpu_pkg::OP_JMP, cpu_pkg::COND_C, 2'd0, 8'd9));
        prog.push_back(encode(cpu_pkg::OP_HALT, 2'd0, 2'd0, 8'd0));
        prog.push_back(encode(cpu_pkg::OP_OUT, 2'd0, 2'd3, 8'd0));
        prog.push_back(encode(cpu_pkg::OP_HALT, 2'd0, 2'd0, 8'd0));
        exp.push_back(8'hF1);
        exp.push_back(8'hC5);
        run_program(prog);
        check_rx_bytes(exp);
    endtask

    task automatic out_keeps_flags();
        cpu_pkg::instr_t prog[$];
        cpu_pkg::word_t  exp[$];
        prog.push_back(encode(cpu_pkg::OP_MOVB, 2'd0, 2'd0, 8'h07));
        prog.push_back(encode(cpu_pkg::OP_MOVB, 2'd1, 2'd0, 8'h00));       // Sets z
        prog.push_back(encode(cpu_pkg::OP_OUT, 2'd0, 2'd0, 8'd0));         // Non-zero byte out
        prog.push_back(encode(cpu_pkg::OP_JMP, cpu_pkg::COND_Z, 2'd0, 8'd5));
        prog.push_back(encode(cpu_pkg::OP_HALT, 2'd0, 2'd0, 8'd0));
        prog.push_back(encode(cpu_pkg::OP_MOVB, 2'd2, 2'd0, 8'hA5));
        prog.push_back(encode(cpu_pkg::OP_OUT, 2'd0, 2'd2, 8'd0));
        prog.push_back(encode(cpu_pkg::OP_HALT, 2'd0, 2'd0, 8'd0));
        exp.push_back(8'h07);
        exp.push_back(8'hA5);
        run_program(prog);
        check_rx_bytes(exp);
    endtask

    task automatic fifo_back_pressure();
        cpu_pkg::instr_t prog[$];
        cpu_pkg::word_t  exp[$];
        cpu_pkg::word_t  v[4];
        for (int r = 0; r < 4; r++) begin
            v[r] = cpu_pkg::word_t'(rand_bits(8));
            prog.push_back(encode(cpu_pkg::OP_MOVB, r[1:0], 2'd0, v[r]));
        end
        for (int i = 0; i < 10; i++) begin
            prog.push_back(encode(cpu_pkg::OP_OUT, 2'd0, i[1:0], 8'd0));   // Faster than the line
            exp.push_back(v[i[1:0]]);
        end
        prog.push_back(encode(cpu_pkg::OP_HALT, 2'd0, 2'd0, 8'd0));
        run_program(prog);
        check_rx_bytes(exp);
    endtask

    task automatic busy_write_protect();
        cpu_pkg::instr_t prog[$];
        cpu_pkg::instr_t guard;
        cpu_pkg::instr_t rd;
        logic            err;
        guard = rand_bits(16);
        prog.push_back(encode(cpu_pkg::OP_MOVB, 2'd0, 2'd0, 8'd200));      // Long spin
        prog.push_back(encode(cpu_pkg::OP_SUB, 2'd0, 2'd0, 8'd1));
        prog.push_back(encode(cpu_pkg::OP_JMP, cpu_pkg::COND_NZ, 2'd0, 8'd1));
        prog.push_back(encode(cpu_pkg::OP_HALT, 2'd0, 2'd0, 8'd0));
        prog.push_back(guard);
        load_program(prog);
        start_program();
        apb_read(CTRL, rd);
        check_bit("busy", rd[0], 1'b1);
        apb_write(word_addr(4), ~guard, err);
        check_bit("host_pslverr", err, 1'b1);
        wait_idle();
        apb_read(CTRL, rd);
        check_bit("busy", rd[0], 1'b0);
        apb_read(word_addr(4), rd);
        check_instr("prog word 4", rd, guard);
    endtask

    initial begin
        rst_n        = 1'b0;
        host_paddr   = '0;
        host_psel    = 1'b0;
        host_penable = 1'b0;
        host_pwrite  = 1'b0;
        host_pwdata  = '0;
        repeat (4) @(posedge system_clk);
        rst_n <= 1'b1;
        program_memory_readback();
        immediate_alu_ops();
        countdown_loop();
        carry_jump();
        out_keeps_flags();
        fifo_back_pressure();
        busy_write_protect();
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_host_port.sv
logic/cpu_controller.sv
logic/cpu_register_file.sv
logic/cpu_alu.sv
logic/uart_tx_fifo.sv
logic/uart_tx.sv
logic/cpu.sv
tb/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the cpu testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module cpu_tb -o cpu_sim \
    && ./obj_dir/cpu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -qx "TEST OK" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
